// File: all.f
tnoc_config_pkg.sv
tnoc_flit_pkg.sv
tnoc_input_port.sv
tnoc_switch_allocator.sv
tnoc_output_port.sv
tnoc_router.sv
tnoc_router_tb.sv

// File: tnoc_config_pkg.sv
package tnoc_config_pkg;

  // ==========================================================
  // Router sizing
  // ==========================================================

  localparam int TNOC_PORTS              = 4;
  localparam int TNOC_ID_WIDTH           = 2;
  localparam int TNOC_DATA_WIDTH         = 32;
  localparam int TNOC_TAG_WIDTH          = 4;
  localparam int TNOC_BURST_WIDTH        = 4;

  // Input FIFO depth when the top level does not override it
  localparam int TNOC_DEFAULT_FIFO_DEPTH = 4;

  // ==========================================================
  // Id and port types
  // ==========================================================

  // One id per router port, so TNOC_PORTS == 2**TNOC_ID_WIDTH
  typedef logic [TNOC_ID_WIDTH-1:0] tnoc_id_t;

  // One bit per port, for requests, routes and grants
  typedef logic [TNOC_PORTS-1:0] tnoc_port_mask_t;

endpackage

// File: tnoc_flit_pkg.sv
package tnoc_flit_pkg;

  import tnoc_config_pkg::*;

  // ==========================================================
  // Flit layout
  // ==========================================================

  localparam int TNOC_HEADER_PAD_WIDTH =
    TNOC_DATA_WIDTH - 2 * TNOC_ID_WIDTH - TNOC_TAG_WIDTH - TNOC_BURST_WIDTH;

  typedef enum logic {
    TNOC_FLIT_HEAD    = 1'b0,
    TNOC_FLIT_PAYLOAD = 1'b1
  } tnoc_flit_kind_e;

  // Header view, destination id sits in the low bits
  typedef struct packed {
    logic [TNOC_HEADER_PAD_WIDTH-1:0] reserved;
    logic [TNOC_BURST_WIDTH-1:0]      burst_length;
    logic [TNOC_TAG_WIDTH-1:0]        tag;
    tnoc_id_t                         source_id;
    tnoc_id_t                         destination_id;
  } tnoc_header_t;

  // Payload view, the whole word is data
  typedef struct packed {
    logic [TNOC_DATA_WIDTH-1:0] data;
  } tnoc_payload_t;

  // Same bits, decoded by flit kind
  typedef union packed {
    tnoc_header_t  header;
    tnoc_payload_t payload;
  } tnoc_flit_data_u;

  typedef struct packed {
    tnoc_flit_kind_e kind;
    logic            tail;
    tnoc_flit_data_u data;
  } tnoc_flit_t;

endpackage

// File: tnoc_input_port.sv
`timescale 1ns/1ps

module tnoc_input_port
  import tnoc_config_pkg::*, tnoc_flit_pkg::*;
#(
  parameter int FIFO_DEPTH = TNOC_DEFAULT_FIFO_DEPTH
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  tnoc_flit_t      in_flit_i,
  output logic            req_valid_o,
  output tnoc_port_mask_t req_route_o,
  output tnoc_flit_t      req_flit_o,
  input  logic            grant_i
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  tnoc_flit_t           mem_q [FIFO_DEPTH];
  ptr_t                 wr_ptr_q;
  ptr_t                 rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;
  tnoc_flit_t           head_flit;
  tnoc_port_mask_t      head_route;
  tnoc_port_mask_t      route_q;
  logic                 in_packet_q;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ==========================================================
  // Circular FIFO
  // ==========================================================

  assign full       = (count_q == CNT_WIDTH'(FIFO_DEPTH));
  assign empty      = (count_q == '0);
  assign in_ready_o = !full;
  assign push       = in_valid_i && !full;
  assign pop        = grant_i && !empty;
  assign head_flit  = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ==========================================================
  // Route lookup
  // ==========================================================

  // Output index is the destination id
  always_comb begin
    head_route = '0;
    head_route[head_flit.data.header.destination_id] = 1'b1;
  end

  // Payload flits follow the route latched from their head
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_packet_q <= 1'b0;
      route_q     <= '0;
    end else if (pop) begin
      if (head_flit.tail) begin
        in_packet_q <= 1'b0;
      end else if (!in_packet_q) begin
        in_packet_q <= 1'b1;
        route_q     <= head_route;
      end
    end
  end

  assign req_valid_o = !empty;
  assign req_route_o = in_packet_q ? route_q : head_route;
  assign req_flit_o  = head_flit;

  // Count agrees with the pointers at both ends
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (full || empty) |-> (wr_ptr_q == rd_ptr_q));

  // Allocator only grants a presented request
  assert property (@(posedge clk) disable iff (!arst_n_i)
    grant_i |-> req_valid_o);

  // A packet starts with a head flit
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (pop && !in_packet_q) |-> (head_flit.kind == TNOC_FLIT_HEAD));

endmodule

// File: tnoc_output_port.sv
`timescale 1ns/1ps

module tnoc_output_port
  import tnoc_flit_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  tnoc_flit_t in_flit_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output tnoc_flit_t out_flit_o
);

  logic       valid_q;
  tnoc_flit_t flit_q;
  logic       load;

  // Takes a new flit when empty or when the current one leaves
  assign in_ready_o = !valid_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      flit_q <= in_flit_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_flit_o  = flit_q;

  // Upstream holds a refused flit until the slice takes it
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (in_valid_i && !in_ready_o) |=> (in_valid_i && $stable(in_flit_i)));

endmodule

// File: tnoc_router.sv
`timescale 1ns/1ps

module tnoc_router
  import tnoc_config_pkg::*, tnoc_flit_pkg::*;
#(
  parameter int FIFO_DEPTH = TNOC_DEFAULT_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       flit_in_valid_i  [TNOC_PORTS],
  output logic       flit_in_ready_o  [TNOC_PORTS],
  input  tnoc_flit_t flit_in_i        [TNOC_PORTS],
  output logic       flit_out_valid_o [TNOC_PORTS],
  input  logic       flit_out_ready_i [TNOC_PORTS],
  output tnoc_flit_t flit_out_o       [TNOC_PORTS]
);

  // Input side to allocator
  logic            req_valid [TNOC_PORTS];
  tnoc_port_mask_t req_route [TNOC_PORTS];
  tnoc_flit_t      req_flit  [TNOC_PORTS];
  wire tnoc_port_mask_t grant;

  // Allocator to output side
  wire tnoc_port_mask_t xbar_valid;
  wire tnoc_port_mask_t xbar_ready;
  tnoc_flit_t      xbar_flit [TNOC_PORTS];

  // ==========================================================
  // Input ports
  // ==========================================================

  for (genvar g = 0; g < TNOC_PORTS; g++) begin : g_in
    tnoc_input_port #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) input_port_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (flit_in_valid_i[g]),
      .in_ready_o  (flit_in_ready_o[g]),
      .in_flit_i   (flit_in_i[g]),
      .req_valid_o (req_valid[g]),
      .req_route_o (req_route[g]),
      .req_flit_o  (req_flit[g]),
      .grant_i     (grant[g])
    );
  end

  // ==========================================================
  // Switch allocation and crossbar
  // ==========================================================

  tnoc_switch_allocator allocator_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid),
    .req_route_i (req_route),
    .req_flit_i  (req_flit),
    .grant_o     (grant),
    .out_valid_o (xbar_valid),
    .out_flit_o  (xbar_flit),
    .out_ready_i (xbar_ready)
  );

  // ==========================================================
  // Output ports
  // ==========================================================

  for (genvar g = 0; g < TNOC_PORTS; g++) begin : g_out
    tnoc_output_port output_port_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (xbar_valid[g]),
      .in_ready_o  (xbar_ready[g]),
      .in_flit_i   (xbar_flit[g]),
      .out_valid_o (flit_out_valid_o[g]),
      .out_ready_i (flit_out_ready_i[g]),
      .out_flit_o  (flit_out_o[g])
    );
  end

endmodule

// File: tnoc_router_tb.sv
`timescale 1ns/1ps

module tnoc_router_tb
  import tnoc_config_pkg::*, tnoc_flit_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 500;

  logic       clk;
  logic       arst_n_i;
  logic       in_valid  [TNOC_PORTS];
  logic       in_ready  [TNOC_PORTS];
  tnoc_flit_t in_flit   [TNOC_PORTS];
  logic       out_valid [TNOC_PORTS];
  logic       out_ready [TNOC_PORTS];
  tnoc_flit_t out_flit  [TNOC_PORTS];

  // Expected flits, indexed by source * TNOC_PORTS + output
  tnoc_flit_t  exp_q [TNOC_PORTS*TNOC_PORTS][$];
  tnoc_id_t    cur_src [TNOC_PORTS];
  logic        open_q  [TNOC_PORTS];
  logic        stall_en;
  logic [31:0] lfsr_q;

  tnoc_router #(
    .FIFO_DEPTH (4)
  ) dut_i (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .flit_in_valid_i  (in_valid),
    .flit_in_ready_o  (in_ready),
    .flit_in_i        (in_flit),
    .flit_out_valid_o (out_valid),
    .flit_out_ready_i (out_ready),
    .flit_out_o       (out_flit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // Error reporting and compare tasks
  // ==========================================================

  task automatic report_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic stop_with_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    report_failure();
  endtask

  task automatic check_flit(input tnoc_flit_t got, input tnoc_flit_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_port(input tnoc_id_t got, input tnoc_id_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // ==========================================================
  // Driver, monitor and scoreboard
  // ==========================================================

  task automatic send_packet(input tnoc_id_t src, input tnoc_id_t dst, input int n_pay);
    tnoc_flit_t flits[$];
    tnoc_flit_t f;
    int         wait_cnt;
    f = '0;
    f.kind = TNOC_FLIT_HEAD;
    f.tail = (n_pay == 0);
    f.data.header.destination_id = dst;
    f.data.header.source_id = src;
    f.data.header.tag = TNOC_TAG_WIDTH'(rand_bits(TNOC_TAG_WIDTH));
    f.data.header.burst_length = TNOC_BURST_WIDTH'(n_pay);
    flits.push_back(f);
    for (int i = 0; i < n_pay; i++) begin
      f.kind = TNOC_FLIT_PAYLOAD;
      f.tail = (i == n_pay - 1);
      f.data.payload.data = rand_bits(TNOC_DATA_WIDTH);
      flits.push_back(f);
    end
    foreach (flits[i]) begin
      exp_q[int'(src) * TNOC_PORTS + int'(dst)].push_back(flits[i]);
    end
    @(posedge clk);
    foreach (flits[i]) begin
      in_valid[src] <= 1'b1;
      in_flit[src]  <= flits[i];
      wait_cnt = 0;
      do begin
        @(posedge clk);
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) begin
          stop_with_error("input port did not accept a flit in time");
        end
      end while (!in_ready[src]);
    end
    in_valid[src] <= 1'b0;
  endtask

  // A head is looked up by its source and destination, so a misrouted
  // packet still finds the flit that was sent
  task automatic take_flit(input tnoc_id_t port, input tnoc_flit_t f);
    int         idx;
    tnoc_flit_t exp_flit;
    if (f.kind == TNOC_FLIT_HEAD) begin
      if (open_q[port]) begin
        stop_with_error("head flit arrived inside an open packet");
      end
      cur_src[port] = f.data.header.source_id;
      open_q[port]  = 1'b1;
      idx = int'(f.data.header.source_id) * TNOC_PORTS + int'(f.data.header.destination_id);
    end else begin
      if (!open_q[port]) begin
        stop_with_error("payload flit arrived outside a packet");
      end
      idx = int'(cur_src[port]) * TNOC_PORTS + int'(port);
    end
    if (exp_q[idx].size() == 0) begin
      stop_with_error("flit arrived with nothing expected for its source and output");
    end
    exp_flit = exp_q[idx].pop_front();
    if (f.kind == TNOC_FLIT_HEAD) begin
      check_port(port, exp_flit.data.header.destination_id, "output port of packet");
    end
    check_flit(f, exp_flit, "output flit");
    if (f.tail) begin
      open_q[port] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (arst_n_i) begin
      for (int o = 0; o < TNOC_PORTS; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          take_flit(tnoc_id_t'(o), out_flit[o]);
        end
      end
    end
  end

  // Random output stalls, ready three times in four
  always @(posedge clk) begin
    if (stall_en) begin
      for (int o = 0; o < TNOC_PORTS; o++) begin
        out_ready[o] <= (rand_bits(2) != 0);
      end
    end
  end

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int i = 0; i < TNOC_PORTS * TNOC_PORTS; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    int wait_cnt;
    wait_cnt = 0;
    while (pending_flits() != 0) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYCLES) begin
        stop_with_error("packets still in flight after the drain timeout");
      end
    end
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================

  task automatic apply_reset();
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);
    for (int p = 0; p < TNOC_PORTS; p++) begin
      if (out_valid[p] || !in_ready[p]) begin
        stop_with_error("router ports are not idle after reset");
      end
    end
  endtask

  task automatic route_single_packet();
    send_packet(2'd0, 2'd2, 3);
    wait_drain();
  endtask

  task automatic cover_all_pairs();
    for (int s = 0; s < TNOC_PORTS; s++) begin
      for (int d = 0; d < TNOC_PORTS; d++) begin
        send_packet(tnoc_id_t'(s), tnoc_id_t'(d), int'(rand_bits(2)));
      end
    end
    wait_drain();
  endtask

  task automatic contend_for_output();
    fork
      send_packet(2'd0, 2'd3, 5);
      send_packet(2'd1, 2'd3, 5);
    join
    wait_drain();
  endtask

  task automatic stall_output();
    tnoc_flit_t held;
    int         wait_cnt;
    out_ready[1] <= 1'b0;
    fork
      send_packet(2'd3, 2'd1, 7);
      begin
        wait_cnt = 0;
        do begin
          @(posedge clk);
          wait_cnt++;
          if (wait_cnt > TIMEOUT_CYCLES) begin
            stop_with_error("stalled output never raised valid");
          end
        end while (!out_valid[1]);
        held = out_flit[1];
        repeat (3) begin
          @(posedge clk);
          if (!out_valid[1]) begin
            stop_with_error("output valid dropped while stalled");
          end
          check_flit(out_flit[1], held, "stalled output flit");
        end
        wait_cnt = 0;
        do begin
          @(posedge clk);
          wait_cnt++;
          if (wait_cnt > TIMEOUT_CYCLES) begin
            stop_with_error("input ready never fell under back-pressure");
          end
        end while (in_ready[3]);
        out_ready[1] <= 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic random_stream(input tnoc_id_t src);
    repeat (6) begin
      send_packet(src, tnoc_id_t'(rand_bits(2)), int'(rand_bits(2)));
    end
  endtask

  task automatic mix_random_traffic();
    stall_en = 1'b1;
    fork
      random_stream(2'd0);
      random_stream(2'd1);
      random_stream(2'd2);
      random_stream(2'd3);
    join
    stall_en = 1'b0;
    @(posedge clk);
    for (int o = 0; o < TNOC_PORTS; o++) begin
      out_ready[o] <= 1'b1;
    end
    wait_drain();
  endtask

  initial begin
    lfsr_q   = 32'ha4c75c37;
    stall_en = 1'b0;
    arst_n_i = 1'b0;
    for (int p = 0; p < TNOC_PORTS; p++) begin
      in_valid[p]  = 1'b0;
      in_flit[p]   = '0;
      out_ready[p] = 1'b1;
      cur_src[p]   = '0;
      open_q[p]    = 1'b0;
    end
    apply_reset();
    route_single_packet();
    cover_all_pairs();
    contend_for_output();
    stall_output();
    mix_random_traffic();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: tnoc_switch_allocator.sv
`timescale 1ns/1ps

module tnoc_switch_allocator
  import tnoc_config_pkg::*, tnoc_flit_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            req_valid_i [TNOC_PORTS],
  input  tnoc_port_mask_t req_route_i [TNOC_PORTS],
  input  tnoc_flit_t      req_flit_i  [TNOC_PORTS],
  output tnoc_port_mask_t grant_o,
  output tnoc_port_mask_t out_valid_o,
  output tnoc_flit_t      out_flit_o  [TNOC_PORTS],
  input  tnoc_port_mask_t out_ready_i
);

  // Indexed [output][input]
  tnoc_port_mask_t out_req    [TNOC_PORTS];
  tnoc_port_mask_t gnt_matrix [TNOC_PORTS];
  // Indexed [input][output]
  tnoc_port_mask_t gnt_by_input [TNOC_PORTS];

  tnoc_id_t        sel     [TNOC_PORTS];
  tnoc_id_t        rr_q    [TNOC_PORTS];
  tnoc_id_t        owner_q [TNOC_PORTS];
  tnoc_port_mask_t lock_q;
  tnoc_port_mask_t out_fire;

  // First requester at or after start, wrapping around
  function automatic tnoc_id_t rr_pick(tnoc_port_mask_t req, tnoc_id_t start);
    tnoc_id_t idx;
    tnoc_id_t pick;
    pick = start;
    for (int k = TNOC_PORTS - 1; k >= 0; k--) begin
      idx = start + tnoc_id_t'(k);
      if (req[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  // ==========================================================
  // Arbitration and crossbar
  // ==========================================================

  always_comb begin
    for (int o = 0; o < TNOC_PORTS; o++) begin
      for (int i = 0; i < TNOC_PORTS; i++) begin
        out_req[o][i] = req_valid_i[i] && req_route_i[i][o];
      end
      sel[o]         = lock_q[o] ? owner_q[o] : rr_pick(out_req[o], rr_q[o]);
      out_valid_o[o] = out_req[o][sel[o]];
      out_flit_o[o]  = req_flit_i[sel[o]];
      out_fire[o]    = out_valid_o[o] && out_ready_i[o];
      gnt_matrix[o]  = '0;
      gnt_matrix[o][sel[o]] = out_fire[o];
    end
    for (int i = 0; i < TNOC_PORTS; i++) begin
      for (int o = 0; o < TNOC_PORTS; o++) begin
        gnt_by_input[i][o] = gnt_matrix[o][i];
      end
      grant_o[i] = |gnt_by_input[i];
    end
  end

  // Lock holds from first presentation until the tail is taken
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= '0;
      for (int o = 0; o < TNOC_PORTS; o++) begin
        rr_q[o]    <= '0;
        owner_q[o] <= '0;
      end
    end else begin
      for (int o = 0; o < TNOC_PORTS; o++) begin
        if (out_fire[o] && out_flit_o[o].tail) begin
          lock_q[o] <= 1'b0;
          rr_q[o]   <= sel[o] + 1'b1;
        end else if (out_valid_o[o]) begin
          lock_q[o]  <= 1'b1;
          owner_q[o] <= sel[o];
        end
      end
    end
  end

  for (genvar g = 0; g < TNOC_PORTS; g++) begin : g_check
    // An output stays with one input until the tail passes
    assert property (@(posedge clk) disable iff (!arst_n_i)
      (out_fire[g] && !out_flit_o[g].tail) |=> (sel[g] == $past(sel[g])));

    // An input never wins two outputs at once
    assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(gnt_by_input[g]));
  end

endmodule
